// File: hdl/ps2_kbd_pkg.sv
package ps2_kbd_pkg;

	////////////////////////////////
	// basic types
	////////////////////////////////

	// one byte as it comes off the PS/2 data line.
	typedef logic [7:0] scan_code_t;

	// 7-bit ASCII, bit 7 is never needed.
	typedef logic [6:0] ascii_t;

	// held modifier keys plus the caps lock latch.
	typedef struct packed {
		logic shift_l;
		logic shift_r;
		logic ctrl_l;
		logic ctrl_r;
		logic caps_lock;
	} modifier_t;

	// characters a key can produce in each plane.
	// the has_* flags mark which planes carry a character at all.
	typedef struct packed {
		ascii_t base_char;
		ascii_t shift_char;
		ascii_t ctrl_char;
		logic has_base;
		logic has_shift;
		logic has_ctrl;
		logic is_letter;
	} map_entry_t;

	////////////////////////////////
	// scan code constants
	////////////////////////////////

	// prefix bytes, folded into flags on the following code.
	localparam scan_code_t BREAK_PREFIX = 8'hf0;
	localparam scan_code_t EXT_PREFIX = 8'he0;

	// modifier keys of scan code set 2.
	localparam scan_code_t SC_SHIFT_L = 8'h12;
	localparam scan_code_t SC_SHIFT_R = 8'h59;

	// left control, or right control when extended.
	localparam scan_code_t SC_CTRL = 8'h14;

	localparam scan_code_t SC_CAPS = 8'h58;

endpackage

// File: hdl/scan_event_if.sv
interface scan_event_if;

	// one-cycle strobe, the rest is only valid alongside it.
	logic valid;
	ps2_kbd_pkg::scan_code_t code;

	// set when the code was preceded by F0 or E0.
	logic is_break;
	logic is_ext;

	modport source (
		output valid, code, is_break, is_ext
	);

	modport sink (
		input valid, code, is_break, is_ext
	);

endinterface

// File: hdl/ps2_scan_receiver.sv
module ps2_scan_receiver #(
	parameter int DEBOUNCE_BITS = 8
) (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	output ps2_kbd_pkg::scan_code_t ps2_code,
	output logic ps2_code_new,
	scan_event_if.source evt
);

	localparam int IDLE_BITS = DEBOUNCE_BITS + 4;

	// index 0 is the PS/2 clock line, index 1 the data line.
	logic [1:0] line_meta;
	logic [1:0] line_sync;
	logic [1:0] line_filt;
	logic [DEBOUNCE_BITS-1:0] stable_cnt [2];

	logic clk_filt_d;
	logic clk_fall;
	logic [10:0] frame;
	logic [10:0] frame_next;
	logic [3:0] bit_cnt;
	logic [IDLE_BITS-1:0] idle_cnt;
	logic frame_end;
	logic frame_ok;
	ps2_kbd_pkg::scan_code_t rx_byte;
	logic pend_break;
	logic pend_ext;

	//////////////////////////////
	// line conditioning
	//////////////////////////////

	// both lines idle high.
	always_ff @(posedge clk) begin
		if (rst) begin
			line_meta <= 2'b11;
			line_sync <= 2'b11;
		end else begin
			line_meta <= {ps2_data, ps2_clk};
			line_sync <= line_meta;
		end
	end

	// a new level is taken only after a full run of the counter.
	always_ff @(posedge clk) begin
		if (rst) begin
			line_filt <= 2'b11;
			for (int i = 0; i < 2; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (line_sync[i] == line_filt[i]) begin
					stable_cnt[i] <= '0;
				end else if (&stable_cnt[i]) begin
					line_filt[i] <= line_sync[i];
					stable_cnt[i] <= '0;
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// frame assembly
	//////////////////////////////

	assign clk_fall = clk_filt_d & ~line_filt[0];
	assign frame_end = clk_fall && (bit_cnt == 4'd10);

	// lsb first, so after eleven shifts the start bit sits in bit 0.
	assign frame_next = {line_filt[1], frame[10:1]};
	assign rx_byte = frame_next[8:1];
	assign frame_ok = ~frame_next[0] & (^frame_next[9:1]) & frame_next[10];

	always_ff @(posedge clk) begin
		if (clk_fall) begin
			frame <= frame_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_filt_d <= 1'b1;
			bit_cnt <= '0;
			idle_cnt <= '0;
			ps2_code_new <= 1'b0;
			evt.valid <= 1'b0;
			pend_break <= 1'b0;
			pend_ext <= 1'b0;
		end else begin
			clk_filt_d <= line_filt[0];
			ps2_code_new <= 1'b0;
			evt.valid <= 1'b0;
			if (clk_fall) begin
				idle_cnt <= '0;
				bit_cnt <= frame_end ? 4'd0 : bit_cnt + 4'd1;
				if (frame_end && frame_ok) begin
					ps2_code_new <= 1'b1;
					if (rx_byte == ps2_kbd_pkg::BREAK_PREFIX) begin
						pend_break <= 1'b1;
					end else if (rx_byte == ps2_kbd_pkg::EXT_PREFIX) begin
						pend_ext <= 1'b1;
					end else begin
						evt.valid <= 1'b1;
						pend_break <= 1'b0;
						pend_ext <= 1'b0;
					end
				end
			end else if (bit_cnt != 4'd0 && line_filt[0]) begin
				// keyboard went quiet in mid frame, start over.
				if (&idle_cnt) begin
					bit_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end else begin
				idle_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_end && frame_ok) begin
			ps2_code <= rx_byte;
			evt.code <= rx_byte;
			evt.is_break <= pend_break;
			evt.is_ext <= pend_ext;
		end
	end

	// strobes toward the top level and the decoders are single pulses.
	assert property (@(posedge clk) disable iff (rst) ps2_code_new |=> !ps2_code_new);
	assert property (@(posedge clk) disable iff (rst) evt.valid |=> !evt.valid);

endmodule

// File: hdl/modifier_tracker.sv
module modifier_tracker (
	input logic clk,
	input logic rst,
	scan_event_if.sink evt,
	output ps2_kbd_pkg::modifier_t mods
);

	logic make;

	assign make = ~evt.is_break;

	//////////////////////////////
	// modifier state
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			mods <= '0;
		end else if (evt.valid) begin
			case (evt.code)
				ps2_kbd_pkg::SC_SHIFT_L: begin
					mods.shift_l <= make;
				end
				ps2_kbd_pkg::SC_SHIFT_R: begin
					mods.shift_r <= make;
				end
				ps2_kbd_pkg::SC_CTRL: begin
					// E0 14 is the right-hand key.
					if (evt.is_ext) begin
						mods.ctrl_r <= make;
					end else begin
						mods.ctrl_l <= make;
					end
				end
				ps2_kbd_pkg::SC_CAPS: begin
					// caps lock latches on make only.
					if (make) begin
						mods.caps_lock <= ~mods.caps_lock;
					end
				end
				default: begin
					mods <= mods;
				end
			endcase
		end
	end

	// caps lock moves only right after a caps lock make.
	assert property (@(posedge clk) disable iff (rst)
		$changed(mods.caps_lock) |->
			$past(evt.valid && evt.code == ps2_kbd_pkg::SC_CAPS && !evt.is_break));

endmodule

// File: hdl/scan_code_map.sv
module scan_code_map (
	input logic clk,
	input logic rst,
	scan_event_if.sink evt,
	output ps2_kbd_pkg::map_entry_t entry,
	output logic entry_valid,
	output logic entry_break
);

	ps2_kbd_pkg::map_entry_t entry_d;

	//////////////////////////////
	// entry builders
	//////////////////////////////

	// upper case is bit 5 cleared, control is the low five bits.
	function automatic ps2_kbd_pkg::map_entry_t letter_entry(input ps2_kbd_pkg::ascii_t lower);
		ps2_kbd_pkg::map_entry_t e;
		e = '0;
		e.base_char = lower;
		e.shift_char = lower ^ 7'h20;
		e.ctrl_char = lower & 7'h1f;
		e.has_base = 1'b1;
		e.has_shift = 1'b1;
		e.has_ctrl = 1'b1;
		e.is_letter = 1'b1;
		return e;
	endfunction

	function automatic ps2_kbd_pkg::map_entry_t key_entry(input ps2_kbd_pkg::ascii_t base,
			input ps2_kbd_pkg::ascii_t shifted);
		ps2_kbd_pkg::map_entry_t e;
		e = '0;
		e.base_char = base;
		e.shift_char = shifted;
		e.has_base = 1'b1;
		e.has_shift = 1'b1;
		return e;
	endfunction

	function automatic ps2_kbd_pkg::map_entry_t ctrl_key_entry(input ps2_kbd_pkg::ascii_t base,
			input ps2_kbd_pkg::ascii_t shifted, input ps2_kbd_pkg::ascii_t ctrl);
		ps2_kbd_pkg::map_entry_t e;
		e = key_entry(base, shifted);
		e.ctrl_char = ctrl;
		e.has_ctrl = 1'b1;
		return e;
	endfunction

	//////////////////////////////
	// scan code set 2 table
	//////////////////////////////

	always_comb begin
		entry_d = '0;
		if (evt.is_ext) begin
			// only delete is decoded among the extended keys.
			if (evt.code == 8'h71) begin
				entry_d = key_entry(7'h7f, 7'h7f);
			end
		end else begin
			case (evt.code)
				8'h1c: entry_d = letter_entry(7'h61);
				8'h32: entry_d = letter_entry(7'h62);
				8'h21: entry_d = letter_entry(7'h63);
				8'h23: entry_d = letter_entry(7'h64);
				8'h24: entry_d = letter_entry(7'h65);
				8'h2b: entry_d = letter_entry(7'h66);
				8'h34: entry_d = letter_entry(7'h67);
				8'h33: entry_d = letter_entry(7'h68);
				8'h43: entry_d = letter_entry(7'h69);
				8'h3b: entry_d = letter_entry(7'h6a);
				8'h42: entry_d = letter_entry(7'h6b);
				8'h4b: entry_d = letter_entry(7'h6c);
				8'h3a: entry_d = letter_entry(7'h6d);
				8'h31: entry_d = letter_entry(7'h6e);
				8'h44: entry_d = letter_entry(7'h6f);
				8'h4d: entry_d = letter_entry(7'h70);
				8'h15: entry_d = letter_entry(7'h71);
				8'h2d: entry_d = letter_entry(7'h72);
				8'h1b: entry_d = letter_entry(7'h73);
				8'h2c: entry_d = letter_entry(7'h74);
				8'h3c: entry_d = letter_entry(7'h75);
				8'h2a: entry_d = letter_entry(7'h76);
				8'h1d: entry_d = letter_entry(7'h77);
				8'h22: entry_d = letter_entry(7'h78);
				8'h35: entry_d = letter_entry(7'h79);
				8'h1a: entry_d = letter_entry(7'h7a);
				// digit row.
				8'h45: entry_d = key_entry(7'h30, 7'h29);
				8'h16: entry_d = key_entry(7'h31, 7'h21);
				8'h1e: entry_d = ctrl_key_entry(7'h32, 7'h40, 7'h00);
				8'h26: entry_d = key_entry(7'h33, 7'h23);
				8'h25: entry_d = key_entry(7'h34, 7'h24);
				8'h2e: entry_d = key_entry(7'h35, 7'h25);
				8'h36: entry_d = ctrl_key_entry(7'h36, 7'h5e, 7'h1e);
				8'h3d: entry_d = key_entry(7'h37, 7'h26);
				8'h3e: entry_d = key_entry(7'h38, 7'h2a);
				8'h46: entry_d = key_entry(7'h39, 7'h28);
				// punctuation.
				8'h52: entry_d = key_entry(7'h27, 7'h22);
				8'h41: entry_d = key_entry(7'h2c, 7'h3c);
				8'h4e: entry_d = ctrl_key_entry(7'h2d, 7'h5f, 7'h1f);
				8'h49: entry_d = key_entry(7'h2e, 7'h3e);
				8'h4a: entry_d = key_entry(7'h2f, 7'h3f);
				8'h4c: entry_d = key_entry(7'h3b, 7'h3a);
				8'h55: entry_d = key_entry(7'h3d, 7'h2b);
				8'h54: entry_d = ctrl_key_entry(7'h5b, 7'h7b, 7'h1b);
				8'h5d: entry_d = ctrl_key_entry(7'h5c, 7'h7c, 7'h1c);
				8'h5b: entry_d = ctrl_key_entry(7'h5d, 7'h7d, 7'h1d);
				8'h0e: entry_d = key_entry(7'h60, 7'h7e);
				// whitespace and editing keys ignore shift.
				8'h29: entry_d = key_entry(7'h20, 7'h20);
				8'h66: entry_d = key_entry(7'h08, 7'h08);
				8'h0d: entry_d = key_entry(7'h09, 7'h09);
				8'h5a: entry_d = key_entry(7'h0d, 7'h0d);
				8'h76: entry_d = key_entry(7'h1b, 7'h1b);
				// modifiers produce no character of their own.
				ps2_kbd_pkg::SC_SHIFT_L,
				ps2_kbd_pkg::SC_SHIFT_R,
				ps2_kbd_pkg::SC_CTRL,
				ps2_kbd_pkg::SC_CAPS: entry_d = '0;
				default: entry_d = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			entry_valid <= 1'b0;
		end else begin
			entry_valid <= evt.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (evt.valid) begin
			entry <= entry_d;
			entry_break <= evt.is_break;
		end
	end

	assert property (@(posedge clk) disable iff (rst) entry_valid |=> !entry_valid);

endmodule

// File: hdl/ascii_composer.sv
module ascii_composer (
	input logic clk,
	input logic rst,
	input ps2_kbd_pkg::map_entry_t entry,
	input logic entry_valid,
	input logic entry_break,
	input ps2_kbd_pkg::modifier_t mods,
	output ps2_kbd_pkg::ascii_t ascii_code,
	output logic ascii_new
);

	logic ctrl_on;
	logic shift_on;
	logic char_ok;
	ps2_kbd_pkg::ascii_t char_sel;

	assign ctrl_on = mods.ctrl_l | mods.ctrl_r;

	// caps lock flips shift, but only on letters.
	assign shift_on = (mods.shift_l | mods.shift_r) ^ (mods.caps_lock & entry.is_letter);

	//////////////////////////////
	// plane select
	//////////////////////////////

	always_comb begin
		if (ctrl_on) begin
			char_sel = entry.ctrl_char;
			char_ok = entry.has_ctrl;
		end else if (shift_on) begin
			char_sel = entry.shift_char;
			char_ok = entry.has_shift;
		end else begin
			char_sel = entry.base_char;
			char_ok = entry.has_base;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ascii_new <= 1'b0;
		end else begin
			ascii_new <= entry_valid & ~entry_break & char_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (entry_valid) begin
			ascii_code <= char_sel;
		end
	end

	// only keys without a character may move the modifier state.
	assert property (@(posedge clk) disable iff (rst)
		entry_valid && $changed(mods) |-> !(entry.has_base || entry.has_shift || entry.has_ctrl));

endmodule

// File: hdl/ps2_keyboard_top.sv
module ps2_keyboard_top #(
	parameter int DEBOUNCE_BITS = 8
) (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	output ps2_kbd_pkg::scan_code_t ps2_code,
	output logic ps2_code_new,
	output ps2_kbd_pkg::ascii_t ascii_code,
	output logic ascii_new
);

	scan_event_if evt ();

	ps2_kbd_pkg::modifier_t mods;
	ps2_kbd_pkg::map_entry_t entry;
	logic entry_valid;
	logic entry_break;

	////////////////////////////////
	// receive, then decode in parallel
	////////////////////////////////

	ps2_scan_receiver #(
		.DEBOUNCE_BITS(DEBOUNCE_BITS)
	) u_receiver (
		.clk(clk),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.ps2_code(ps2_code),
		.ps2_code_new(ps2_code_new),
		.evt(evt.source)
	);

	modifier_tracker u_tracker (
		.clk(clk),
		.rst(rst),
		.evt(evt.sink),
		.mods(mods)
	);

	scan_code_map u_map (
		.clk(clk),
		.rst(rst),
		.evt(evt.sink),
		.entry(entry),
		.entry_valid(entry_valid),
		.entry_break(entry_break)
	);

	// modifier state and map entry line up on the same cycle.
	ascii_composer u_composer (
		.clk(clk),
		.rst(rst),
		.entry(entry),
		.entry_valid(entry_valid),
		.entry_break(entry_break),
		.mods(mods),
		.ascii_code(ascii_code),
		.ascii_new(ascii_new)
	);

endmodule

// File: testbench/ps2_keyboard_tb.sv
module ps2_keyboard_tb;

	// PS/2 clock half period in system clocks.
	localparam int HALF_BIT = 40;
	// ascii_new trails ps2_code_new by two clocks.
	localparam int ASCII_DELAY = 2;
	localparam int WAIT_LIMIT = 200;
	localparam int QUIET_CYCLES = 60;
	localparam int MAX_FRAMES = 64;

	logic clk;
	logic rst;
	logic ps2_clk;
	logic ps2_data;
	ps2_kbd_pkg::scan_code_t ps2_code;
	logic ps2_code_new;
	ps2_kbd_pkg::ascii_t ascii_code;
	logic ascii_new;

	// four hex fields per frame, see the data file.
	logic [7:0] vec [0:4*MAX_FRAMES-1];
	logic [31:0] seed;
	int frame_cnt;

	ps2_keyboard_top #(
		.DEBOUNCE_BITS(3)
	) UUT (
		.clk(clk),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.ps2_code(ps2_code),
		.ps2_code_new(ps2_code_new),
		.ascii_code(ascii_code),
		.ascii_new(ascii_new)
	);

	always #10 clk = ~clk;

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_scan(input string name, input ps2_kbd_pkg::scan_code_t got,
			input ps2_kbd_pkg::scan_code_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_ascii(input string name, input ps2_kbd_pkg::ascii_t got,
			input ps2_kbd_pkg::ascii_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// start, eight data bits lsb first, odd parity, stop.
	// returns with the PS/2 clock held low after the stop bit.
	task automatic send_frame(input ps2_kbd_pkg::scan_code_t code, input logic bad);
		logic [10:0] bits;
		bits = {1'b1, ~^code ^ bad, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			repeat (HALF_BIT / 2) @(negedge clk);
			ps2_clk = 1'b0;
			if (i != 10) begin
				repeat (HALF_BIT) @(negedge clk);
				ps2_clk = 1'b1;
				repeat (HALF_BIT / 2) @(negedge clk);
			end
		end
	endtask

	//////////////////////////////
	// one frame and its checks
	//////////////////////////////

	task automatic run_frame(input ps2_kbd_pkg::scan_code_t code, input logic bad,
			input logic want, input ps2_kbd_pkg::ascii_t exp_char);
		logic seen;
		int gap;
		seen = 1'b0;
		send_frame(code, bad);
		if (bad) begin
			// a corrupted frame must stay silent.
			repeat (QUIET_CYCLES) begin
				@(negedge clk);
				if (ps2_code_new || ascii_new) begin
					stop_run($sformatf("strobe after corrupted frame %h", code));
				end
			end
		end else begin
			for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
				@(negedge clk);
				if (ascii_new) begin
					stop_run($sformatf("ascii_new pulsed before scan code %h", code));
				end
				seen = ps2_code_new;
			end
			if (!seen) begin
				stop_run($sformatf("timeout waiting for ps2_code_new on %h", code));
			end
			check_scan("ps2_code", ps2_code, code);
			for (int k = 1; k <= ASCII_DELAY + 1; k++) begin
				@(negedge clk);
				if (want && k == ASCII_DELAY) begin
					if (!ascii_new) begin
						stop_run($sformatf("ascii_new missing after scan code %h", code));
					end
					check_ascii("ascii_code", ascii_code, exp_char);
				end else if (ascii_new) begin
					stop_run($sformatf("unexpected ascii_new after scan code %h", code));
				end
			end
		end
		// release the clock line and idle for a random gap.
		ps2_clk = 1'b1;
		seed = lcg_next(seed);
		gap = seed[21:16];
		repeat (HALF_BIT + gap) @(negedge clk);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		seed = 32'hb96678b1;
		frame_cnt = 0;
		for (int i = 0; i < 4 * MAX_FRAMES; i++) begin
			vec[i] = 'x;
		end
		$readmemh("testbench/ps2_testdata.txt", vec);
		repeat (2) @(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk);
		while (frame_cnt < MAX_FRAMES && !$isunknown(vec[4*frame_cnt])) begin
			run_frame(vec[4*frame_cnt], vec[4*frame_cnt+1][0], vec[4*frame_cnt+2][0],
				vec[4*frame_cnt+3][6:0]);
			frame_cnt++;
		end
		if (frame_cnt == 0) begin
			stop_run("no frames were read from the stimulus file");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// File: testbench/ps2_testdata.txt
// columns, all hex: scan byte, corrupt parity flag, ascii expected flag, expected ascii
// one line per PS/2 frame, sent in order
1c 0 1 61
f0 0 0 00
1c 0 0 00
16 0 1 31
29 0 1 20
5a 0 1 0d
12 0 0 00
32 0 1 42
16 0 1 21
f0 0 0 00
12 0 0 00
58 0 0 00
f0 0 0 00
58 0 0 00
21 0 1 43
59 0 0 00
21 0 1 63
45 0 1 29
f0 0 0 00
59 0 0 00
45 0 1 30
58 0 0 00
14 0 0 00
1c 0 1 01
f0 0 0 00
14 0 0 00
e0 0 0 00
14 0 0 00
1a 0 1 1a
e0 0 0 00
f0 0 0 00
14 0 0 00
1c 0 1 61
e0 0 0 00
71 0 1 7f
e0 0 0 00
75 0 0 00
24 1 0 00
24 0 1 65

// File: src.f
hdl/ps2_kbd_pkg.sv
hdl/scan_event_if.sv
hdl/ps2_scan_receiver.sv
hdl/modifier_tracker.sv
hdl/scan_code_map.sv
hdl/ascii_composer.sv
hdl/ps2_keyboard_top.sv
testbench/ps2_keyboard_tb.sv
